// ==== source/exec_pkg.sv ====
package exec_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int md_steps   = 32;
    localparam int md_cnt_w   = $clog2(md_steps);

    // Positions in the produce and ready vectors
    localparam int n_outs   = 4;
    localparam int out_res  = 0;
    localparam int out_mcmd = 1;
    localparam int out_mreq = 2;
    localparam int out_jmp  = 3;

    localparam int res_pkt_w  = reg_addr_w + xlen;      // rd, value
    localparam int mcmd_pkt_w = reg_addr_w + 3 + 2;     // rd, funct, offset
    localparam int jmp_pkt_w  = 3 + xlen;               // flags, target

    typedef enum logic [2:0] {
        op_alu    = 3'd0,
        op_load   = 3'd1,
        op_store  = 3'd2,
        op_branch = 3'd3,
        op_jump   = 3'd4,
        op_muldiv = 3'd5
    } op_type_e;

    typedef enum logic [2:0] {
        alu_add_sub = 3'b000,
        alu_sll     = 3'b001,
        alu_slt     = 3'b010,
        alu_sltu    = 3'b011,
        alu_xor     = 3'b100,
        alu_srl_sra = 3'b101,
        alu_or      = 3'b110,
        alu_and     = 3'b111
    } alu_funct_e;

    // Stores share these widths (sb, sh, sw)
    typedef enum logic [2:0] {
        ls_lb  = 3'b000,
        ls_lh  = 3'b001,
        ls_lw  = 3'b010,
        ls_lbu = 3'b100,
        ls_lhu = 3'b101
    } ls_funct_e;

    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } br_funct_e;

    typedef enum logic [2:0] {
        md_mul   = 3'b000,
        md_mulhu = 3'b011,
        md_divu  = 3'b101,
        md_remu  = 3'b111
    } md_funct_e;

    // funct3 field, meaning picked by op_type
    typedef union packed {
        alu_funct_e alu;
        ls_funct_e  ls;
        br_funct_e  br;
        md_funct_e  md;
    } exec_funct_u;

endpackage

// ==== source/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if import exec_pkg::*; ();

    logic            valid;
    logic            ready;
    logic            read_enable;
    logic [3:0]      write_enable;   // Byte lane mask
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;

    modport core (
        output valid, read_enable, write_enable, addr, data,
        input  ready
    );

    modport stage (
        input  valid, read_enable, write_enable, addr, data,
        output ready
    );

endinterface

// ==== source/exec_alu.sv ====
`timescale 1ns/1ps

module exec_alu import exec_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  exec_funct_u     funct,
    input  op_type_e        op_type,
    input  logic            alt,
    output logic [xlen-1:0] result,
    output logic [xlen-1:0] sum,
    output logic            take_branch
);

    logic                       sub;
    logic [xlen:0]              full;
    logic                       eq;
    logic                       lt;
    logic                       ltu;
    logic [$clog2(xlen)-1:0]    shamt;
    logic signed [xlen-1:0]     sra_res;

    always_comb begin
        case (op_type)
            op_branch: sub = 1'b1;
            op_alu:    sub = (funct.alu == alu_slt) || (funct.alu == alu_sltu) ||
                             ((funct.alu == alu_add_sub) && alt);
            default:   sub = 1'b0;
        endcase
    end

    // Carry out of a + ~b + 1 means no borrow
    assign full    = {1'b0, a} + {1'b0, (sub ? ~b : b)} + {{xlen{1'b0}}, sub};
    assign sum     = full[xlen-1:0];
    assign eq      = (a == b);
    assign ltu     = !full[xlen];
    assign lt      = (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : sum[xlen-1];
    assign shamt   = b[$clog2(xlen)-1:0];
    assign sra_res = $signed(a) >>> shamt;

    always_comb begin
        case (funct.alu)
            alu_add_sub: result = sum;
            alu_sll:     result = a << shamt;
            alu_slt:     result = {{(xlen-1){1'b0}}, lt};
            alu_sltu:    result = {{(xlen-1){1'b0}}, ltu};
            alu_xor:     result = a ^ b;
            alu_srl_sra: result = alt ? sra_res : (a >> shamt);
            alu_or:      result = a | b;
            default:     result = a & b;
        endcase
    end

    always_comb begin
        case (funct.br)
            br_beq:  take_branch = eq;
            br_bne:  take_branch = !eq;
            br_blt:  take_branch = lt;
            br_bge:  take_branch = !lt;
            br_bltu: take_branch = ltu;
            br_bgeu: take_branch = !ltu;
            default: take_branch = 1'b0;
        endcase
    end

endmodule

// ==== source/exec_muldiv.sv ====
`timescale 1ns/1ps

module exec_muldiv import exec_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            enable,
    input  logic            start,
    input  md_funct_e       funct,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic            busy,
    output logic            last,
    output logic [xlen-1:0] result
);

    logic [md_cnt_w-1:0] count;
    md_funct_e           op;
    md_funct_e           src_op;
    logic [2*xlen-1:0]   acc;
    logic [2*xlen-1:0]   src_acc;
    logic [2*xlen-1:0]   acc_next;
    logic [xlen-1:0]     opb;
    logic [xlen-1:0]     src_b;
    logic [xlen:0]       psum;
    logic [xlen+1:0]     trial;

    assign busy = (count != '0);
    assign last = (count == md_cnt_w'(md_steps - 1));

    // Start applies step zero straight to the incoming operands
    assign src_acc = start ? {{xlen{1'b0}}, a} : acc;
    assign src_b   = start ? b : opb;
    assign src_op  = start ? funct : op;

    // Upper half holds the partial product or the remainder
    always_comb begin
        psum  = {1'b0, src_acc[2*xlen-1:xlen]} + (src_acc[0] ? {1'b0, src_b} : '0);
        trial = {1'b0, src_acc[2*xlen-1:xlen-1]} - {2'b00, src_b};
        if ((src_op == md_mul) || (src_op == md_mulhu)) begin
            acc_next = {psum, src_acc[xlen-1:1]};
        end else if (!trial[xlen+1]) begin
            acc_next = {trial[xlen-1:0], src_acc[xlen-2:0], 1'b1};   // Quotient bit set
        end else begin
            acc_next = {src_acc[2*xlen-2:0], 1'b0};                  // Restore
        end
    end

    always_comb begin
        case (src_op)
            md_mulhu, md_remu: result = acc_next[2*xlen-1:xlen];
            default:           result = acc_next[xlen-1:0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (enable) begin
            if (start) begin
                count <= md_cnt_w'(1);
            end else if (busy) begin
                count <= count + md_cnt_w'(1);   // Wraps to zero after the last step
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable && (start || busy)) begin
            acc <= acc_next;
        end
        if (enable && start) begin
            opb <= b;
            op  <= funct;
        end
    end

endmodule

// ==== source/exec_stream_ctrl.sv ====
`timescale 1ns/1ps

module exec_stream_ctrl import exec_pkg::*; (
    input  logic              cmd_valid,
    input  logic              consume,
    input  logic [n_outs-1:0] produce,
    input  logic [n_outs-1:0] out_ready,
    output logic              cmd_ready,
    output logic              enable,
    output logic [n_outs-1:0] out_valid
);

    logic [n_outs-1:0] blocked;

    // An output only stalls the stage if this command writes to it
    assign blocked = produce & ~out_ready;

    assign enable    = cmd_valid && (blocked == '0);
    assign cmd_ready = enable && consume;
    assign out_valid = produce & {n_outs{enable}};

endmodule

// ==== source/exec_out_slice.sv ====
`timescale 1ns/1ps

module exec_out_slice #(
    parameter int width = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  logic [width-1:0] in_data,
    output logic             in_ready,
    output logic             out_valid,
    output logic [width-1:0] out_data,
    input  logic             out_ready
);

    // Free when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== source/exec_mem_slice.sv ====
`timescale 1ns/1ps

module exec_mem_slice import exec_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    mem_req_if.stage        req_in,
    output logic            req_out_valid,
    output logic            req_out_read_enable,
    output logic [3:0]      req_out_write_enable,
    output logic [xlen-1:0] req_out_addr,
    output logic [xlen-1:0] req_out_data,
    input  logic            req_out_ready
);

    logic load;

    assign req_in.ready = !req_out_valid || req_out_ready;
    assign load         = req_in.valid && req_in.ready;

    // Enables drop to zero whenever the stage empties
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_out_valid        <= 1'b0;
            req_out_read_enable  <= 1'b0;
            req_out_write_enable <= 4'b0000;
        end else if (req_in.ready) begin
            req_out_valid        <= req_in.valid;
            req_out_read_enable  <= req_in.valid && req_in.read_enable;
            req_out_write_enable <= req_in.valid ? req_in.write_enable : 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            req_out_addr <= req_in.addr;
            req_out_data <= req_in.data;
        end
    end

endmodule

// ==== source/exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  op_type_e              cmd_op_type,
    input  exec_funct_u           cmd_funct,
    input  logic                  cmd_alt,
    input  logic                  cmd_fwd_rs1,
    input  logic                  cmd_fwd_rs2,
    input  logic [xlen-1:0]       cmd_rs1,
    input  logic [xlen-1:0]       cmd_rs2,
    input  logic [xlen-1:0]       cmd_store_data,
    input  logic [xlen-1:0]       cmd_imm,
    input  logic [xlen-1:0]       cmd_pc,
    input  logic [xlen-1:0]       cmd_next_pc,
    input  logic [reg_addr_w-1:0] cmd_rd,

    output logic                  res_valid,
    input  logic                  res_ready,
    output logic [reg_addr_w-1:0] res_rd,
    output logic [xlen-1:0]       res_value,

    output logic                  mcmd_valid,
    input  logic                  mcmd_ready,
    output logic [reg_addr_w-1:0] mcmd_rd,
    output ls_funct_e             mcmd_funct,
    output logic [1:0]            mcmd_offset,

    output logic                  mreq_valid,
    input  logic                  mreq_ready,
    output logic                  mreq_read_enable,
    output logic [3:0]            mreq_write_enable,
    output logic [xlen-1:0]       mreq_addr,
    output logic [xlen-1:0]       mreq_data,

    output logic                  jmp_valid,
    input  logic                  jmp_ready,
    output logic                  jmp_branched,
    output logic                  jmp_jumped,
    output logic [xlen-1:0]       jmp_target,
    output logic                  jmp_update_pc
);

    mem_req_if mreq_next ();

    logic [xlen-1:0]       last_value;
    logic [xlen-1:0]       opnd_a;
    logic [xlen-1:0]       opnd_b;
    logic [xlen-1:0]       alu_b;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       alu_sum;
    logic                  take_branch;
    logic                  md_start;
    logic                  md_busy;
    logic                  md_last;
    logic [xlen-1:0]       md_result;
    logic                  enable;
    logic                  consume;
    logic [n_outs-1:0]     produce;
    logic [n_outs-1:0]     stage_ready;
    logic [n_outs-1:0]     stage_valid;
    logic [1:0]            offset;
    logic [xlen-1:0]       link;
    logic [xlen-1:0]       res_next;
    logic [xlen-1:0]       store_lanes;
    logic [3:0]            store_mask;
    logic [xlen-1:0]       jmp_next_target;
    logic                  jmp_next_branched;
    logic                  jmp_next_jumped;
    logic [res_pkt_w-1:0]  res_pkt;
    logic [mcmd_pkt_w-1:0] mcmd_pkt;
    logic [2:0]            mcmd_funct_bits;
    logic [jmp_pkt_w-1:0]  jmp_pkt;

    assign opnd_a = cmd_fwd_rs1 ? last_value : cmd_rs1;
    assign opnd_b = cmd_fwd_rs2 ? last_value : cmd_rs2;

    // Address and jump target use the immediate
    assign alu_b = ((cmd_op_type == op_load) || (cmd_op_type == op_store) ||
                    (cmd_op_type == op_jump)) ? cmd_imm : opnd_b;

    assign offset   = alu_sum[1:0];
    assign link     = cmd_pc + xlen'(4);
    assign md_start = (cmd_op_type == op_muldiv) && !md_busy;

    always_comb begin
        case (cmd_funct.ls)
            ls_lb: begin
                store_lanes = xlen'(cmd_store_data[7:0]) << {offset, 3'b000};
                store_mask  = 4'b0001 << offset;
            end
            ls_lh: begin
                store_lanes = xlen'(cmd_store_data[15:0]) << {offset, 3'b000};
                store_mask  = 4'b0011 << offset;
            end
            default: begin
                store_lanes = cmd_store_data;
                store_mask  = 4'b1111;
            end
        endcase
    end

    always_comb begin
        produce                = '0;
        consume                = 1'b1;
        res_next               = alu_result;
        jmp_next_branched      = 1'b0;
        jmp_next_jumped        = 1'b0;
        jmp_next_target        = link;
        mreq_next.read_enable  = 1'b0;
        mreq_next.write_enable = 4'b0000;
        mreq_next.data         = '0;
        case (cmd_op_type)
            op_alu: produce[out_res] = 1'b1;
            op_load: begin
                produce[out_mreq]     = 1'b1;
                produce[out_mcmd]     = 1'b1;
                mreq_next.read_enable = 1'b1;
            end
            op_store: begin
                produce[out_mreq]      = 1'b1;
                mreq_next.write_enable = store_mask;
                mreq_next.data         = store_lanes;
            end
            op_branch: begin
                produce[out_jmp]  = 1'b1;
                jmp_next_branched = take_branch;
                jmp_next_target   = take_branch ? (cmd_pc + cmd_imm) : link;
            end
            op_jump: begin
                produce[out_jmp] = 1'b1;
                produce[out_res] = (cmd_rd != '0);   // No write to x0
                res_next         = link;
                jmp_next_jumped  = 1'b1;
                jmp_next_target  = alu_sum;
            end
            op_muldiv: begin
                // Held until the final iteration
                consume          = md_last;
                produce[out_res] = md_last;
                res_next         = md_result;
            end
            default: produce = '0;
        endcase
    end

    assign mreq_next.valid = stage_valid[out_mreq];
    assign mreq_next.addr  = alu_sum;
    assign stage_ready[out_mreq] = mreq_next.ready;

    always_ff @(posedge clk) begin
        if (stage_valid[out_res]) begin
            last_value <= res_next;
        end
    end

    exec_alu alu_i (
        .a(opnd_a), .b(alu_b), .funct(cmd_funct), .op_type(cmd_op_type), .alt(cmd_alt),
        .result(alu_result), .sum(alu_sum), .take_branch(take_branch)
    );

    exec_muldiv muldiv_i (
        .clk, .rst_n, .enable, .start(md_start), .funct(cmd_funct.md),
        .a(opnd_a), .b(opnd_b), .busy(md_busy), .last(md_last), .result(md_result)
    );

    exec_stream_ctrl ctrl_i (
        .cmd_valid, .consume, .produce, .out_ready(stage_ready),
        .cmd_ready, .enable, .out_valid(stage_valid)
    );

    exec_out_slice #(.width(res_pkt_w)) res_slice_i (
        .clk, .rst_n,
        .in_valid(stage_valid[out_res]), .in_data({cmd_rd, res_next}),
        .in_ready(stage_ready[out_res]),
        .out_valid(res_valid), .out_data(res_pkt), .out_ready(res_ready)
    );

    exec_out_slice #(.width(mcmd_pkt_w)) mcmd_slice_i (
        .clk, .rst_n,
        .in_valid(stage_valid[out_mcmd]), .in_data({cmd_rd, cmd_funct.ls, offset}),
        .in_ready(stage_ready[out_mcmd]),
        .out_valid(mcmd_valid), .out_data(mcmd_pkt), .out_ready(mcmd_ready)
    );

    exec_out_slice #(.width(jmp_pkt_w)) jmp_slice_i (
        .clk, .rst_n,
        .in_valid(stage_valid[out_jmp]),
        .in_data({jmp_next_branched, jmp_next_jumped,
                  (jmp_next_target != cmd_next_pc), jmp_next_target}),
        .in_ready(stage_ready[out_jmp]),
        .out_valid(jmp_valid), .out_data(jmp_pkt), .out_ready(jmp_ready)
    );

    exec_mem_slice mreq_slice_i (
        .clk, .rst_n, .req_in(mreq_next),
        .req_out_valid(mreq_valid), .req_out_read_enable(mreq_read_enable),
        .req_out_write_enable(mreq_write_enable), .req_out_addr(mreq_addr),
        .req_out_data(mreq_data), .req_out_ready(mreq_ready)
    );

    assign {res_rd, res_value} = res_pkt;
    assign {mcmd_rd, mcmd_funct_bits, mcmd_offset} = mcmd_pkt;
    assign mcmd_funct = ls_funct_e'(mcmd_funct_bits);
    assign {jmp_branched, jmp_jumped, jmp_update_pc, jmp_target} = jmp_pkt;

endmodule

// ==== tb/exec_stage_assertions.sv ====
`timescale 1ns/1ps

module exec_stage_assertions import exec_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  res_valid,
    input logic                  res_ready,
    input logic [reg_addr_w-1:0] res_rd,
    input logic [xlen-1:0]       res_value,
    input logic                  mcmd_valid,
    input logic                  mcmd_ready,
    input logic [reg_addr_w-1:0] mcmd_rd,
    input ls_funct_e             mcmd_funct,
    input logic [1:0]            mcmd_offset,
    input logic                  mreq_valid,
    input logic                  mreq_ready,
    input logic                  mreq_read_enable,
    input logic [3:0]            mreq_write_enable,
    input logic [xlen-1:0]       mreq_addr,
    input logic [xlen-1:0]       mreq_data,
    input logic                  jmp_valid,
    input logic                  jmp_ready,
    input logic                  jmp_branched,
    input logic                  jmp_jumped,
    input logic                  jmp_update_pc,
    input logic [xlen-1:0]       jmp_target
);

    // Payload held while the consumer stalls
    assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && $stable({res_rd, res_value}))
        else $error("result output changed while stalled");
    assert property (@(posedge clk) disable iff (!rst_n)
        mcmd_valid && !mcmd_ready |=>
            mcmd_valid && $stable({mcmd_rd, mcmd_funct, mcmd_offset}))
        else $error("memory command changed while stalled");
    assert property (@(posedge clk) disable iff (!rst_n)
        mreq_valid && !mreq_ready |=> mreq_valid &&
            $stable({mreq_read_enable, mreq_write_enable, mreq_addr, mreq_data}))
        else $error("memory request changed while stalled");
    assert property (@(posedge clk) disable iff (!rst_n)
        jmp_valid && !jmp_ready |=> jmp_valid &&
            $stable({jmp_branched, jmp_jumped, jmp_update_pc, jmp_target}))
        else $error("jump record changed while stalled");

    assert property (@(posedge clk)
        !rst_n |=> !(res_valid || mcmd_valid || mreq_valid || jmp_valid))
        else $error("output valid high during reset");

endmodule

bind exec_stage exec_stage_assertions assertions_i (.*);

// ==== tb/exec_stage_tb.sv ====
`timescale 1ns/1ps

module exec_stage_tb import exec_pkg::*; ();

    typedef struct {
        string           name;
        op_type_e        op;
        logic [2:0]      funct;
        logic            alt;
        logic            fwd1;
        logic [xlen-1:0] rs1, rs2, sdata, imm, pc, npc;
        logic [4:0]      rd;
        logic [3:0]      outs;                // res, mcmd, mreq, jmp
        logic [71:0]     exp [4];
    } test_t;

    logic clk, rst_n;
    logic cmd_valid, cmd_ready, cmd_alt, cmd_fwd_rs1, cmd_fwd_rs2;
    op_type_e cmd_op_type;
    exec_funct_u cmd_funct;
    logic [xlen-1:0] cmd_rs1, cmd_rs2, cmd_store_data, cmd_imm, cmd_pc, cmd_next_pc;
    logic [4:0] cmd_rd, res_rd, mcmd_rd;
    logic res_valid, res_ready, mcmd_valid, mcmd_ready, mreq_valid, mreq_ready;
    logic jmp_valid, jmp_ready, mreq_read_enable, jmp_branched, jmp_jumped, jmp_update_pc;
    logic [xlen-1:0] res_value, mreq_addr, mreq_data, jmp_target;
    ls_funct_e mcmd_funct;
    logic [1:0] mcmd_offset;
    logic [3:0] mreq_write_enable;

    test_t       tests [$];
    logic [71:0] exp_q [4][$];
    int          id_q [4][$];
    int          pend [$];
    int          errs [$];
    logic [xlen-1:0] model_last;
    int n_pass, n_fail, n_errors, n_done, cycles, limit;

    exec_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [xlen-1:0] alu_model(logic [2:0] f, logic alt,
                                                  logic [xlen-1:0] a, logic [xlen-1:0] b);
        case (f)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 1 : 0;
            3'b011:  return (a < b) ? 1 : 0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? xlen'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(logic [2:0] f, logic [xlen-1:0] a, logic [xlen-1:0] b);
        case (f)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [xlen-1:0] md_model(logic [2:0] f, logic [xlen-1:0] a,
                                                 logic [xlen-1:0] b);
        logic [63:0] p;
        p = {32'd0, a} * {32'd0, b};
        case (f)
            3'b000:  return p[31:0];
            3'b011:  return p[63:32];
            3'b101:  return (b == 0) ? 32'hffff_ffff : a / b;
            default: return (b == 0) ? a : a % b;
        endcase
    endfunction

    // Expected outputs are worked out here as the table is built
    task automatic add_test(string name, op_type_e op, logic [2:0] f, logic alt, logic fwd1,
                            logic [xlen-1:0] rs1, logic [xlen-1:0] rs2, logic [xlen-1:0] sd,
                            logic [xlen-1:0] imm, logic [xlen-1:0] pc, logic [xlen-1:0] npc,
                            logic [4:0] rd);
        test_t t;
        logic [xlen-1:0] a, r, addr, tgt;
        logic tk;
        a = fwd1 ? model_last : rs1;
        addr = a + imm;
        t = '{name: name, op: op, funct: f, alt: alt, fwd1: fwd1, rs1: rs1, rs2: rs2,
              sdata: sd, imm: imm, pc: pc, npc: npc, rd: rd, outs: 4'b0000,
              exp: '{default: '0}};
        case (op)
            op_alu, op_muldiv: begin
                r = (op == op_alu) ? alu_model(f, alt, a, rs2) : md_model(f, a, rs2);
                t.outs = 4'b0001;
                t.exp[0] = {rd, r};
                model_last = r;
            end
            op_load: begin
                t.outs = 4'b0110;
                t.exp[1] = {rd, f, addr[1:0]};
                t.exp[2] = {1'b1, 4'b0000, addr, 32'd0};
            end
            op_store: begin
                t.outs = 4'b0100;
                case (f[1:0])
                    2'b00:   t.exp[2] = {1'b0, 4'b0001 << addr[1:0], addr,
                                         {24'd0, sd[7:0]} << (8 * addr[1:0])};
                    2'b01:   t.exp[2] = {1'b0, 4'b0011 << addr[1:0], addr,
                                         {16'd0, sd[15:0]} << (8 * addr[1:0])};
                    default: t.exp[2] = {1'b0, 4'b1111, addr, sd};
                endcase
            end
            op_branch: begin
                tk = branch_model(f, a, rs2);
                tgt = tk ? pc + imm : pc + 4;
                t.outs = 4'b1000;
                t.exp[3] = {tk, 1'b0, tgt != npc, tgt};
            end
            default: begin
                t.outs = (rd != 0) ? 4'b1001 : 4'b1000;
                t.exp[3] = {1'b0, 1'b1, addr != npc, addr};
                t.exp[0] = {rd, pc + 32'd4};
                if (rd != 0) model_last = pc + 32'd4;
            end
        endcase
        tests.push_back(t);
        pend.push_back($countones(t.outs));
        errs.push_back(0);
    endtask

    task automatic check_out(int k, string out_name, logic [71:0] act);
        int id;
        logic [71:0] exp;
        if (exp_q[k].size() == 0) begin
            $display("Unexpected transfer on the %s output with nothing expected", out_name);
            n_errors++;
            return;
        end
        exp = exp_q[k].pop_front();
        id = id_q[k].pop_front();
        if (act != exp) begin
            $display("Fail %s %s: expected %h actual %h", tests[id].name, out_name, exp, act);
            errs[id]++;
            n_errors++;
        end
        pend[id]--;
        if (pend[id] == 0) begin
            n_done++;
            if (errs[id] == 0) begin
                $display("pass %s", tests[id].name);
                n_pass++;
            end else begin
                $display("Fail %s with %0d wrong values", tests[id].name, errs[id]);
                n_fail++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (res_valid && res_ready) check_out(0, "result", {res_rd, res_value});
            if (mcmd_valid && mcmd_ready)
                check_out(1, "mem cmd", {mcmd_rd, mcmd_funct, mcmd_offset});
            if (mreq_valid && mreq_ready)
                check_out(2, "mem req", {mreq_read_enable, mreq_write_enable, mreq_addr,
                                         (mreq_write_enable != 0) ? mreq_data : 32'd0});
            if (jmp_valid && jmp_ready)
                check_out(3, "jump", {jmp_branched, jmp_jumped, jmp_update_pc, jmp_target});
        end
    end

    always @(negedge clk) begin
        res_ready  <= ($urandom % 10) < 7;
        mcmd_ready <= ($urandom % 10) < 7;
        mreq_ready <= ($urandom % 10) < 7;
        jmp_ready  <= ($urandom % 10) < 7;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles with %0d of %0d tests done",
                     cycles, n_done, tests.size());
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(98478));
        {rst_n, cmd_valid, cmd_alt, cmd_fwd_rs1, cmd_fwd_rs2} = '0;
        {res_ready, mcmd_ready, mreq_ready, jmp_ready} = '0;
        cmd_op_type = op_alu;
        cmd_funct = '0;
        {cmd_rs1, cmd_rs2, cmd_store_data, cmd_imm, cmd_pc, cmd_next_pc, cmd_rd} = '0;
        {n_pass, n_fail, n_errors, n_done, cycles, limit} = '0;
        model_last = '0;

        add_test("add", op_alu, 3'b000, 0, 0, 32'h7fff_ffff, 32'd1, 0, 0, 0, 0, 5'd1);
        add_test("sub", op_alu, 3'b000, 1, 0, 32'h8000_0000, 32'd1, 0, 0, 0, 0, 5'd2);
        add_test("sll", op_alu, 3'b001, 0, 0, 32'h8000_0001, 32'd31, 0, 0, 0, 0, 5'd3);
        add_test("slt", op_alu, 3'b010, 0, 0, 32'hffff_fffb, 32'd3, 0, 0, 0, 0, 5'd4);
        add_test("sltu", op_alu, 3'b011, 0, 0, 32'hffff_fffb, 32'd3, 0, 0, 0, 0, 5'd5);
        add_test("xor", op_alu, 3'b100, 0, 0, 32'hf0f0_f0f0, 32'hff00_ff00, 0, 0, 0, 0, 5'd6);
        add_test("srl", op_alu, 3'b101, 0, 0, 32'h8000_0000, 32'd4, 0, 0, 0, 0, 5'd7);
        add_test("sra", op_alu, 3'b101, 1, 0, 32'h8000_0000, 32'd4, 0, 0, 0, 0, 5'd8);
        add_test("or", op_alu, 3'b110, 0, 0, 32'h1234_0000, 32'h0000_5678, 0, 0, 0, 0, 5'd9);
        add_test("and", op_alu, 3'b111, 0, 0, 32'hffff_0000, 32'h0ff0_0ff0, 0, 0, 0, 0, 5'd10);
        add_test("fwd_add", op_alu, 3'b000, 0, 1, 32'hdead_beef, 32'd16, 0, 0, 0, 0, 5'd11);
        add_test("lw", op_load, 3'b010, 0, 0, 32'h1000, 0, 0, 32'h20, 0, 0, 5'd12);
        add_test("lbu_off3", op_load, 3'b100, 0, 0, 32'h1001, 0, 0, 32'h2, 0, 0, 5'd13);
        for (int i = 0; i < 4; i++)
            add_test($sformatf("sb_off%0d", i), op_store, 3'b000, 0, 0, 32'h2000 + i, 0,
                     32'h1122_33a5, 0, 0, 0, 0);
        add_test("sh_off0", op_store, 3'b001, 0, 0, 32'h2000, 0, 32'h1122_b6c7, 0, 0, 0, 0);
        add_test("sh_off2", op_store, 3'b001, 0, 0, 32'h2000, 0, 32'h1122_b6c7, 2, 0, 0, 0);
        add_test("sw", op_store, 3'b010, 0, 0, 32'h2ff0, 0, 32'hcafe_f00d, 32'h10, 0, 0, 0);
        add_test("beq_taken", op_branch, 3'b000, 0, 0, 5, 5, 0, 32'h40, 32'h100, 32'h104, 0);
        add_test("bne_not", op_branch, 3'b001, 0, 0, 5, 5, 0, 32'h40, 32'h100, 32'h104, 0);
        add_test("blt_taken", op_branch, 3'b100, 0, 0, 32'hffff_ffff, 1, 0, 32'hffff_fff0,
                 32'h200, 32'h1f0, 0);
        add_test("bgeu_not", op_branch, 3'b111, 0, 0, 1, 32'hffff_ffff, 0, 32'h8,
                 32'h300, 32'h308, 0);
        add_test("jal", op_jump, 3'b000, 0, 0, 32'h400, 0, 0, 32'h80, 32'h400, 32'h404, 5'd1);
        add_test("jalr_x0", op_jump, 3'b000, 0, 0, 32'h1234, 0, 0, 32'h4, 32'h500, 32'h1238, 0);
        add_test("mul", op_muldiv, 3'b000, 0, 0, $urandom, $urandom, 0, 0, 0, 0, 5'd14);
        add_test("mulhu", op_muldiv, 3'b011, 0, 0, $urandom, $urandom, 0, 0, 0, 0, 5'd15);
        add_test("divu", op_muldiv, 3'b101, 0, 0, $urandom, $urandom % 1000, 0, 0, 0, 0, 5'd16);
        add_test("remu", op_muldiv, 3'b111, 0, 0, $urandom, $urandom % 1000, 0, 0, 0, 0, 5'd17);
        add_test("divu_zero", op_muldiv, 3'b101, 0, 0, $urandom, 0, 0, 0, 0, 0, 5'd18);
        add_test("remu_zero", op_muldiv, 3'b111, 0, 0, 32'h1357_9bdf, 0, 0, 0, 0, 0, 5'd19);
        limit = tests.size() * 40 + 200;

        repeat (10) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;

        for (int i = 0; i < tests.size(); i++) begin
            @(negedge clk);
            cmd_valid = 1'b1;
            cmd_op_type = tests[i].op;
            cmd_funct = tests[i].funct;
            cmd_alt = tests[i].alt;
            cmd_fwd_rs1 = tests[i].fwd1;
            cmd_rs1 = tests[i].rs1;
            cmd_rs2 = tests[i].rs2;
            cmd_store_data = tests[i].sdata;
            cmd_imm = tests[i].imm;
            cmd_pc = tests[i].pc;
            cmd_next_pc = tests[i].npc;
            cmd_rd = tests[i].rd;
            @(posedge clk);
            // A finished MUL/DIV has its result held in the output stage by now
            if (i > 0 && tests[i-1].op == op_muldiv && !res_valid) begin
                $display("Result of %s missing when %s was offered",
                         tests[i-1].name, tests[i].name);
                n_errors++;
            end
            while (!cmd_ready) @(posedge clk);
            for (int k = 0; k < 4; k++) begin
                if (tests[i].outs[k]) begin
                    exp_q[k].push_back(tests[i].exp[k]);
                    id_q[k].push_back(i);
                end
            end
        end
        @(negedge clk) cmd_valid = 1'b0;
        while (n_done < tests.size()) @(posedge clk);
        repeat (5) @(posedge clk);

        $display("Tests passed %0d, failed %0d, wrong values %0d, leftover %0d",
                 n_pass, n_fail, n_errors,
                 exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size());
        if (n_fail == 0 && n_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== exec_stage.f ====
source/exec_pkg.sv
source/mem_req_if.sv
source/exec_alu.sv
source/exec_muldiv.sv
source/exec_stream_ctrl.sv
source/exec_out_slice.sv
source/exec_mem_slice.sv
source/exec_stage.sv
tb/exec_stage_assertions.sv
tb/exec_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module exec_stage_tb -f exec_stage.f
./obj_dir/Vexec_stage_tb 2>&1 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
